// ==== hdl/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // --------------------
    // Datapath widths

    localparam int w_sample   = 24;  // INMP441 word
    localparam int w_sound    = 16;  // Audio DAC word
    localparam int w_seg      = 8;   // abcdefgh
    localparam int n_digit    = 6;   // HEX0 .. HEX5
    localparam int w_meter    = 10;  // LEDR
    localparam int meter_base = 13;  // LED 0 lights at 2**13

    // --------------------
    // Hex font, abcdefgh, active high
    // The point h stays dark for every glyph

    localparam logic [15:0][w_seg - 1:0] hex_font =
    {
        8'b1000_1110,  // F
        8'b1001_1110,  // E
        8'b0111_1010,  // d
        8'b1001_1100,  // C
        8'b0011_1110,  // b
        8'b1110_1110,  // A
        8'b1111_0110,  // 9
        8'b1111_1110,  // 8
        8'b1110_0000,  // 7
        8'b1011_1110,  // 6
        8'b1011_0110,  // 5
        8'b0110_0110,  // 4
        8'b1111_0010,  // 3
        8'b1101_1010,  // 2
        8'b0110_0000,  // 1
        8'b1111_1100   // 0
    };

endpackage

`default_nettype wire

// ==== hdl/seven_segment_display.sv ====
`default_nettype none

module seven_segment_display
    import board_pkg::*;
#(
    parameter int clk_mhz = 50                  // Sets the refresh period
)
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire  [4 * n_digit - 1:0]  number,   // Nibble n shows on digit n
    output logic [w_seg - 1:0]        abcdefgh,
    output logic [n_digit - 1:0]      digit     // One-hot select
);

    localparam int period = clk_mhz * 1000;     // One millisecond per digit
    localparam int w_cnt  = $clog2(period);

    logic [w_cnt - 1:0] cnt;
    logic [3:0]         nibble;

    // --------------------
    // Refresh scan

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt   <= '0;
            digit <= n_digit'(1);               // Start on HEX0
        end
        else if (cnt == w_cnt'(period - 1))
        begin
            cnt   <= '0;
            digit <= {digit[n_digit - 2:0], digit[n_digit - 1]};  // Rotate left
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    // --------------------
    // Digit decode

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < n_digit; i++)
        begin
            if (digit[i])
            begin
                nibble = number[4 * i +: 4];
            end
        end
    end

    assign abcdefgh = hex_font[nibble];

    digit_one_hot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(digit)
    );

endmodule

`default_nettype wire

// ==== hdl/inmp441_mic_i2s_receiver.sv ====
`default_nettype none

module inmp441_mic_i2s_receiver
    import board_pkg::*;
#(
    parameter int sck_div = 4                   // Clocks per half sck period
)
(
    input  wire                    clk,
    input  wire                    rst,
    output logic                   lr,          // Channel select to the mic
    output logic                   ws,
    output logic                   sck,
    input  wire                    sd,
    output logic [w_sample - 1:0]  value,
    output logic                   value_valid
);

    localparam int w_div = sck_div > 1 ? $clog2(sck_div) : 1;

    logic [w_div - 1:0]    div_cnt;
    logic                  div_end;
    logic                  sck_rise;            // sck goes high on the next edge
    logic                  sck_fall;
    logic [5:0]            bit_cnt;             // sck periods in the stereo frame
    logic [w_sample - 1:0] shift;

    assign lr = 1'b0;                           // Mic answers in the left slot

    // --------------------
    // sck and ws generation

    assign div_end  = div_cnt == w_div'(sck_div - 1);
    assign sck_rise = div_end & ~sck;
    assign sck_fall = div_end & sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else if (div_end)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
            if (sck_fall)
            begin
                bit_cnt <= bit_cnt + 1'b1;      // ws flips with sck falling
            end
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign ws = bit_cnt[5];                     // Low half is the left slot

    // --------------------
    // Capture, MSB first

    always_ff @(posedge clk)
    begin
        if (sck_rise)
        begin
            shift <= {shift[w_sample - 2:0], sd};
        end
        if (sck_rise && bit_cnt == 6'd24)
        begin
            value <= {shift[w_sample - 2:0], sd};   // Bit 0 arrives now
        end
    end

    // Bit 23 at period 1, bit 0 at period 24
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            value_valid <= 1'b0;
        end
        else
        begin
            value_valid <= sck_rise && bit_cnt == 6'd24;
        end
    end

    ws_on_low_sck: assert property (
        @(posedge clk) disable iff (rst)
        $changed(ws) |-> !sck
    );

endmodule

`default_nettype wire

// ==== hdl/i2s_audio_out.sv ====
`default_nettype none

module i2s_audio_out
    import board_pkg::*;
#(
    parameter int sck_div = 4                   // Clocks per half bclk period
)
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire  [w_sound - 1:0]  sound,
    output logic                  mclk,
    output logic                  bclk,
    output logic                  lrclk,
    output logic                  sdata
);

    localparam int w_div = sck_div > 1 ? $clog2(sck_div) : 1;

    logic [w_div - 1:0]   div_cnt;
    logic                 div_end;
    logic                 bclk_fall;
    logic [5:0]           frame_cnt;            // bclk periods, 32 per channel
    logic [w_sound - 1:0] shift;

    // --------------------
    // Clocks

    assign div_end   = div_cnt == w_div'(sck_div - 1);
    assign bclk_fall = div_end & bclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk      <= 1'b0;
            div_cnt   <= '0;
            bclk      <= 1'b0;
            frame_cnt <= '0;
        end
        else
        begin
            mclk <= ~mclk;                      // Half the system clock
            if (div_end)
            begin
                div_cnt <= '0;
                bclk    <= ~bclk;
                if (bclk_fall)
                begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    assign lrclk = frame_cnt[5];                // Left slot while low

    // --------------------
    // Serializer
    // Word loads as lrclk falls, MSB goes out one bclk later
    // Zeros fill the rest of the left slot and all of the right one

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shift <= '0;
            sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            sdata <= shift[w_sound - 1];
            if (frame_cnt == '1)
            begin
                shift <= sound;                 // Latest sample, held level
            end
            else
            begin
                shift <= shift << 1;
            end
        end
    end

    sdata_on_low_bclk: assert property (
        @(posedge clk) disable iff (rst)
        $changed(sdata) |-> !bclk
    );

endmodule

`default_nettype wire

// ==== hdl/top.sv ====
`default_nettype none

module top
    import board_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       key,          // Key 0, high while held
    input  wire                       sw,           // Switch 0, audio on
    output logic [w_meter - 1:0]      led,
    input  wire  [w_sample - 1:0]     value,        // Signed mic sample
    input  wire                       value_valid,
    output logic [4 * n_digit - 1:0]  number,       // Six hex digits
    output logic [w_sound - 1:0]      sound
);

    logic [w_sample - 1:0] magnitude;
    logic [w_meter - 1:0]  level;

    // --------------------
    // Level meter

    always_comb
    begin
        magnitude = value[w_sample - 1] ? -value : value;  // Full scale negative stays 2**23
    end

    // Thermometer code, one LED per octave above 2**meter_base
    always_comb
    begin
        for (int i = 0; i < w_meter; i++)
        begin
            level[i] = magnitude >= (w_sample'(1) << (meter_base + i));
        end
    end

    // --------------------
    // Output registers, loaded once per sample

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            led    <= '0;
            number <= '0;
            sound  <= '0;
        end
        else if (value_valid)
        begin
            led <= level;

            if (!key)
            begin
                number <= value[4 * n_digit - 1:0];  // Display frozen while key held
            end

            sound <= sw ? value[w_sample - 1 -: w_sound] : '0;  // Mute on switch low
        end
    end

    // The receiver strobes at most once per frame
    valid_single: assert property (
        @(posedge clk) disable iff (rst)
        value_valid |=> !value_valid
    );

endmodule

`default_nettype wire

// ==== hdl/board_specific_top.sv ====
`default_nettype none

module board_specific_top
    import board_pkg::*;
#(
    parameter int clk_mhz = 50,                 // Board oscillator
    parameter int sck_div = 4                   // Clocks per half bit clock
)
(
    input  wire                  MAX10_CLK1_50,

    input  wire  [1:0]           KEY,           // Active low
    input  wire  [9:0]           SW,            // SW 9 is the reset
    output logic [w_meter - 1:0] LEDR,

    output logic [w_seg - 1:0]   HEX0,          // Active low, hgfedcba
    output logic [w_seg - 1:0]   HEX1,
    output logic [w_seg - 1:0]   HEX2,
    output logic [w_seg - 1:0]   HEX3,
    output logic [w_seg - 1:0]   HEX4,
    output logic [w_seg - 1:0]   HEX5,

    output logic                 VGA_HS,
    output logic                 VGA_VS,
    output logic [3:0]           VGA_R,
    output logic [3:0]           VGA_G,
    output logic [3:0]           VGA_B,

    inout  wire  [35:0]          GPIO
);

    // --------------------
    // Board controls

    logic                      clk;
    logic                      rst;
    logic                      hold_key;        // Key 0 pressed

    logic [w_seg - 1:0]        abcdefgh;
    logic [w_seg - 1:0]        hgfedcba;
    logic [n_digit - 1:0]      digit;
    logic [4 * n_digit - 1:0]  number;

    logic [w_sample - 1:0]     mic_value;
    logic                      mic_valid;
    logic [w_sound - 1:0]      sound;

    logic                      mic_lr;
    logic                      mic_ws;
    logic                      mic_sck;
    logic                      mic_sd;
    logic                      aud_mclk;
    logic                      aud_bclk;
    logic                      aud_lrclk;
    logic                      aud_sdata;

    logic [w_seg - 1:0]        hex_reg [n_digit];

    assign clk      = MAX10_CLK1_50;
    assign rst      = SW[9];
    assign hold_key = ~KEY[0];                  // Keys pull low when pressed

    // No VGA in this lab
    assign VGA_HS = 1'b0;
    assign VGA_VS = 1'b0;
    assign VGA_R  = '0;
    assign VGA_G  = '0;
    assign VGA_B  = '0;

    // --------------------
    // Lab core

    top i_top
    (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .key         ( hold_key  ),
        .sw          ( SW[0]     ),
        .led         ( LEDR      ),
        .value       ( mic_value ),
        .value_valid ( mic_valid ),
        .number      ( number    ),
        .sound       ( sound     )
    );

    seven_segment_display #(.clk_mhz (clk_mhz)) i_display
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .number   ( number   ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    // --------------------
    // Sticky display registers

    for (genvar i = 0; i < w_seg; i++)
    begin : g_rev
        assign hgfedcba[i] = abcdefgh[w_seg - 1 - i];   // Board wires h to bit 7
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int n = 0; n < n_digit; n++)
            begin
                hex_reg[n] <= '1;                       // Blank
            end
        end
        else
        begin
            for (int n = 0; n < n_digit; n++)
            begin
                if (digit[n])
                begin
                    hex_reg[n] <= ~hgfedcba;            // Segments light on low
                end
            end
        end
    end

    assign HEX0 = hex_reg[0];
    assign HEX1 = hex_reg[1];
    assign HEX2 = hex_reg[2];
    assign HEX3 = hex_reg[3];
    assign HEX4 = hex_reg[4];
    assign HEX5 = hex_reg[5];

    // --------------------
    // I2S pins on the GPIO header

    inmp441_mic_i2s_receiver #(.sck_div (sck_div)) i_microphone
    (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .lr          ( mic_lr    ),
        .ws          ( mic_ws    ),
        .sck         ( mic_sck   ),
        .sd          ( mic_sd    ),
        .value       ( mic_value ),
        .value_valid ( mic_valid )
    );

    assign GPIO[0] = mic_lr;                    // Mic L/R select
    assign GPIO[1] = 1'b0;                      // Mic ground
    assign GPIO[2] = mic_ws;
    assign GPIO[3] = 1'b1;                      // Mic supply
    assign GPIO[4] = mic_sck;
    assign mic_sd  = GPIO[5];

    i2s_audio_out #(.sck_div (sck_div)) o_audio
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .sound ( sound     ),
        .mclk  ( aud_mclk  ),
        .bclk  ( aud_bclk  ),
        .lrclk ( aud_lrclk ),
        .sdata ( aud_sdata )
    );

    assign GPIO[33] = aud_mclk;
    assign GPIO[31] = aud_bclk;
    assign GPIO[27] = aud_lrclk;
    assign GPIO[29] = aud_sdata;

endmodule

`default_nettype wire

// ==== tests/tb_i2s_model.svh ====
`ifndef TB_I2S_MODEL_SVH
`define TB_I2S_MODEL_SVH

// --------------------
// Pin edges, seen on the rising system clock

// Returns one clock after the pin reaches the level given by rising
task automatic await_edge(input int sel, input logic rising);
    @(posedge clk);
    while (!(pins[sel] === rising && pins_q[sel] !== rising))
    begin
        @(posedge clk);
    end
endtask

// --------------------
// Microphone serializer

// Bit 23 goes out after the sck fall that opens period 1 of the left slot
task automatic drive_mic_slot(input logic [w_sample - 1:0] word);
    await_edge(pin_ws, 1'b0);                   // Slot opens, period 0 carries no data
    for (int b = w_sample - 1; b >= 0; b--)
    begin
        await_edge(pin_sck, 1'b0);
        mic_sd <= word[b];                      // Stable well before the next sck rise
    end
    await_edge(pin_sck, 1'b0);
    mic_sd <= 1'b0;                             // Mic tristates, line pulled low
endtask

// --------------------
// Audio deserializer

// MSB sits in bclk period 1 of each slot
task automatic receive_audio_frame(output logic [w_sound - 1:0] left,
                                   output logic [w_sound - 1:0] right);
    left  = '0;
    right = '0;

    await_edge(pin_lrclk, 1'b0);
    for (int k = 0; k <= w_sound; k++)
    begin
        await_edge(pin_bclk, 1'b1);
        if (k > 0)
        begin
            left = {left[w_sound - 2:0], aud_sdata};
        end
    end

    await_edge(pin_lrclk, 1'b1);
    for (int k = 0; k <= w_sound; k++)
    begin
        await_edge(pin_bclk, 1'b1);
        if (k > 0)
        begin
            right = {right[w_sound - 2:0], aud_sdata};
        end
    end
endtask

`endif

// ==== tests/tb_board.sv ====
`default_nettype none

module tb_board
    import board_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_mhz      = 1;                    // 1000 clocks per digit
    localparam int sck_div      = 4;
    localparam int clk_period   = 40;
    localparam int n_samples    = 9;
    localparam int frame_clocks = 64 * 2 * sck_div;     // Both I2S slots
    localparam int scan_clocks  = n_digit * clk_mhz * 1000;
    localparam int step_clocks  = 6 * frame_clocks + scan_clocks;
    localparam int timeout_ns   = (n_samples * step_clocks + 4000) * clk_period;

    // Index of each I2S pin in pins
    localparam int pin_ws    = 0;
    localparam int pin_sck   = 1;
    localparam int pin_lrclk = 2;
    localparam int pin_bclk  = 3;

    // --------------------
    // DUT connections

    logic                  clk;
    logic [1:0]            key;                         // Active low
    logic [9:0]            sw;                          // SW 9 is reset
    wire  [w_meter - 1:0]  ledr;
    wire  [w_seg - 1:0]    hex_out [n_digit];
    wire                   vga_hs;
    wire                   vga_vs;
    wire  [3:0]            vga_r;
    wire  [3:0]            vga_g;
    wire  [3:0]            vga_b;
    wire  [35:0]           gpio;

    logic                  mic_sd;                      // Mic data into GPIO 5
    logic [w_sample - 1:0] mic_word;                    // Word for the coming left slots
    logic [31:0]           rng_state = 32'h676e_e4ca;

    wire                   aud_sdata;
    wire  [3:0]            pins;
    logic [3:0]            pins_q = '0;                 // pins one clock earlier

    assign gpio[5]   = mic_sd;
    assign aud_sdata = gpio[29];
    assign pins      = {gpio[31], gpio[27], gpio[4], gpio[2]};

    always @(posedge clk)
    begin
        pins_q <= pins;
    end

    board_specific_top #(.clk_mhz (clk_mhz), .sck_div (sck_div)) i_dut
    (
        .MAX10_CLK1_50 ( clk        ),
        .KEY           ( key        ),
        .SW            ( sw         ),
        .LEDR          ( ledr       ),
        .HEX0          ( hex_out[0] ),
        .HEX1          ( hex_out[1] ),
        .HEX2          ( hex_out[2] ),
        .HEX3          ( hex_out[3] ),
        .HEX4          ( hex_out[4] ),
        .HEX5          ( hex_out[5] ),
        .VGA_HS        ( vga_hs     ),
        .VGA_VS        ( vga_vs     ),
        .VGA_R         ( vga_r      ),
        .VGA_G         ( vga_g      ),
        .VGA_B         ( vga_b      ),
        .GPIO          ( gpio       )
    );

    `include "tb_i2s_model.svh"

    // --------------------
    // Random words and reference model

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Arithmetic shift spreads magnitudes over the whole meter
    function automatic logic [w_sample - 1:0] random_word();
        logic [31:0] r;
        logic [31:0] s;
        r = next_random();
        s = next_random();
        return $signed(r[w_sample - 1:0]) >>> s[3:0];
    endfunction

    function automatic logic [w_meter - 1:0] expected_meter(input logic [w_sample - 1:0] word);
        logic [31:0]          mag;
        logic [w_meter - 1:0] led;
        mag = word[w_sample - 1] ? (32'd1 << w_sample) - 32'(word) : 32'(word);
        for (int i = 0; i < w_meter; i++)
        begin
            led[i] = mag >= (32'd1 << (meter_base + i));    // One LED per octave
        end
        return led;
    endfunction

    // Board order hgfedcba, lit on low
    function automatic logic [w_seg - 1:0] expected_hex(input logic [3:0] nibble);
        logic [w_seg - 1:0] font;
        logic [w_seg - 1:0] rev;
        font = hex_font[nibble];
        for (int i = 0; i < w_seg; i++)
        begin
            rev[i] = font[w_seg - 1 - i];
        end
        return ~rev;
    endfunction

    // --------------------
    // Compare tasks

    task automatic stop_on_error(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_segment(input string name, input logic [w_seg - 1:0] got,
                                 input logic [w_seg - 1:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("Seven-segment value differs from the model");
        end
    endtask

    task automatic check_led(input logic [w_meter - 1:0] got, input logic [w_meter - 1:0] exp);
        if (got !== exp)
        begin
            $display("FAILED LEDR: got 0x%h, expected 0x%h", got, exp);
            stop_on_error("Level meter differs from the model");
        end
    endtask

    task automatic check_sound(input string name, input logic [w_sound - 1:0] got,
                               input logic [w_sound - 1:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("Audio word differs from the model");
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("Pin level differs from the model");
        end
    endtask

    task automatic check_color(input string name, input logic [3:0] got,
                               input logic [3:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error("VGA color level differs from the model");
        end
    endtask

    task automatic check_blank_outputs();
        for (int n = 0; n < n_digit; n++)
        begin
            check_segment($sformatf("HEX%0d", n), hex_out[n], '1);
        end
        check_led(ledr, '0);
        check_pin("sdata", aud_sdata, 1'b0);
    endtask

    // Unused VGA and the mic power pins never move
    task automatic check_tie_offs();
        check_pin("VGA_HS", vga_hs, 1'b0);
        check_pin("VGA_VS", vga_vs, 1'b0);
        check_color("VGA_R", vga_r, 4'h0);
        check_color("VGA_G", vga_g, 4'h0);
        check_color("VGA_B", vga_b, 4'h0);
        check_pin("GPIO[0]", gpio[0], 1'b0);            // Left channel select
        check_pin("GPIO[1]", gpio[1], 1'b0);            // Mic ground
        check_pin("GPIO[3]", gpio[3], 1'b1);            // Mic supply
    endtask

    // Word goes out in the next left slot, checked one frame later
    task automatic capture_sample(input logic [w_sample - 1:0] word);
        await_edge(pin_ws, 1'b0);                       // Mic latches on ws rise only
        mic_word = word;
        await_edge(pin_ws, 1'b1);
        await_edge(pin_ws, 1'b0);
        await_edge(pin_ws, 1'b0);
    endtask

    // --------------------
    // Clock, mic and watchdog

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial
    begin
        logic [w_sample - 1:0] slot_word;
        forever
        begin
            await_edge(pin_ws, 1'b1);
            slot_word = mic_word;
            drive_mic_slot(slot_word);
        end
    end

    initial
    begin
        #(timeout_ns);
        stop_on_error("Watchdog expired before the test sequence finished");
    end

    // --------------------
    // Test sequence

    initial
    begin
        logic [w_sample - 1:0] word;
        logic [w_sample - 1:0] shown;                   // Word the display should hold
        logic [31:0]           coin;
        logic                  hold;
        logic                  audio_on;
        logic [w_sound - 1:0]  left;
        logic [w_sound - 1:0]  right;
        logic [w_sound - 1:0]  exp_left;

        key      = 2'b11;                               // Released
        sw       = 10'h200;                             // Reset on, audio muted
        mic_sd   = 1'b0;
        mic_word = '0;
        shown    = '0;

        repeat (2) @(posedge clk);
        check_blank_outputs();
        @(posedge clk);
        sw[9] <= 1'b0;
        @(posedge clk);
        check_blank_outputs();                          // Outputs still blank right after reset
        check_tie_offs();
        for (int c = 0; c < 4; c++)
        begin
            check_pin("mclk", gpio[33], c[0]);          // Half the system clock from reset
            @(posedge clk);
        end

        for (int i = 0; i < n_samples; i++)
        begin
            hold     = (i % 3) == 2;
            coin     = next_random();
            audio_on = coin[0];
            @(posedge clk);
            key[0] <= ~hold;
            sw[0]  <= audio_on;

            word = random_word();
            capture_sample(word);
            check_led(ledr, expected_meter(word));

            receive_audio_frame(left, right);
            exp_left = audio_on ? word[w_sample - 1 -: w_sound] : '0;
            check_sound("left word", left, exp_left);
            check_sound("right word", right, '0);

            if (!hold)
            begin
                shown = word;
            end
            repeat (scan_clocks) @(posedge clk);        // Every digit refreshed once
            for (int n = 0; n < n_digit; n++)
            begin
                check_segment($sformatf("HEX%0d", n), hex_out[n], expected_hex(shown[4 * n +: 4]));
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== board_audio.f ====
+incdir+tests
hdl/board_pkg.sv
hdl/seven_segment_display.sv
hdl/inmp441_mic_i2s_receiver.sv
hdl/i2s_audio_out.sv
hdl/top.sv
hdl/board_specific_top.sv
tests/tb_board.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_board
FILELIST   ?= board_audio.f
BUILD_DIR  ?= obj_dir
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# Status comes from the search for the pass line
run: build
	@out=$$(./$(BUILD_DIR)/$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
